// File: source/cop_macros.svh
// Coprocessor sizing macros for the register file and the LFSR reset state
`ifndef COP_MACROS_SVH
`define COP_MACROS_SVH

// Number of coprocessor registers
`define COP_NUM_CPRS 16

// Bits needed to index one CPR
`define COP_CPR_AW 4

// LFSR contents straight after reset
`define COP_RNG_RESET 32'h0000_0000

`endif

// File: source/cop_isa_pkg.sv
// Coprocessor ISA package with the instruction word layout and opcode fields
`default_nettype none

package cop_isa_pkg;

    // One instruction word, two views of the same 32 bits
    typedef union packed {
        struct packed {
            logic [2:0]  iclass;   // Instruction class
            logic [4:0]  subclass; // Operation within the class
            logic [3:0]  rd;       // Destination CPR
            logic [3:0]  rs1;      // First source CPR
            logic [3:0]  rs2;      // Second source CPR
            logic [11:0] unused;
        } rv;                      // Register operand view
        struct packed {
            logic [2:0]  iclass;
            logic [4:0]  subclass;
            logic [3:0]  rd;
            logic [3:0]  rs1;
            logic [15:0] imm;      // Low 5 bits give the rotate amount
        } iv;                      // Immediate operand view
    } instr_t;

    // Class codes, zero and 4..7 are reserved
    localparam logic [2:0] CLASS_MOVE    = 3'd1;
    localparam logic [2:0] CLASS_RANDOM  = 3'd2;
    localparam logic [2:0] CLASS_BITWISE = 3'd3;

    // MOVE subclasses
    localparam logic [4:0] SC_MVCOP = 5'd0;  // Host value into CPR
    localparam logic [4:0] SC_MVGPR = 5'd1;  // CPR value back to host

    // RANDOM subclasses
    localparam logic [4:0] SC_RSEED = 5'd0;
    localparam logic [4:0] SC_RSAMP = 5'd1;
    localparam logic [4:0] SC_RTEST = 5'd2;

    // BITWISE subclasses
    localparam logic [4:0] SC_XOR  = 5'd0;
    localparam logic [4:0] SC_AND  = 5'd1;
    localparam logic [4:0] SC_OR   = 5'd2;
    localparam logic [4:0] SC_ROTL = 5'd3;  // Uses the immediate view

endpackage

`default_nettype wire

// File: source/cop_rng_pkg.sv
// Random source package with the LFSR feedback taps and self-test result
`default_nettype none

package cop_rng_pkg;

    // Feedback taps, new low bit is the XNOR of all four
    localparam int RNG_TAP_A = 31;
    localparam int RNG_TAP_B = 21;
    localparam int RNG_TAP_C = 1;
    localparam int RNG_TAP_D = 0;

    // Word written by RTEST when the source is healthy
    localparam logic [31:0] RTEST_PASS = 32'h0000_0001;

endpackage

`default_nettype wire

// File: source/cop_issue.sv
// Issue controller running the host handshake, decode and writeback select
`default_nettype none

`include "cop_macros.svh"

module cop_issue (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   cop_req,     // Four-phase host request
    input  logic [31:0]            cop_instr,
    input  logic [31:0]            host_rs1,    // Held by host until ack
    input  logic [31:0]            rs1_rdata,
    input  logic [31:0]            rng_wdata,
    input  logic [3:0]             rng_ben,
    input  logic [31:0]            bit_wdata,
    output logic                   cop_ack,
    output logic [31:0]            cop_result,
    output logic                   cop_fault,
    output logic [`COP_CPR_AW-1:0] rs1_addr,
    output logic [`COP_CPR_AW-1:0] rs2_addr,
    output logic [`COP_CPR_AW-1:0] wr_addr,
    output logic [3:0]             wr_ben,
    output logic [31:0]            wr_data,
    output logic                   exec,        // One cycle per instruction
    output logic [4:0]             subclass,
    output logic [4:0]             imm,
    output logic                   rng_sel,
    output logic                   bit_sel
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_EXEC = 2'd1;
    localparam logic [1:0] ST_ACK  = 2'd2;

    logic [1:0]          state;
    logic                req_q;      // Registered host request
    cop_isa_pkg::instr_t instr_q;
    logic [2:0]          iclass;
    logic                legal;
    logic                is_mvcop;
    logic                is_mvgpr;
    logic                use_imm;

    assign iclass   = instr_q.rv.iclass;
    assign subclass = instr_q.rv.subclass;
    assign rs1_addr = instr_q.rv.rs1;
    assign wr_addr  = instr_q.rv.rd;
    assign imm      = instr_q.iv.imm[4:0];   // Rotate amount
    assign use_imm  = bit_sel && (subclass == cop_isa_pkg::SC_ROTL);
    assign rs2_addr = use_imm ? '0 : instr_q.rv.rs2;  // rs2 field is imm here

    assign exec     = (state == ST_EXEC);
    assign rng_sel  = (iclass == cop_isa_pkg::CLASS_RANDOM);
    assign bit_sel  = (iclass == cop_isa_pkg::CLASS_BITWISE);
    assign is_mvcop = (iclass == cop_isa_pkg::CLASS_MOVE) && (subclass == cop_isa_pkg::SC_MVCOP);
    assign is_mvgpr = (iclass == cop_isa_pkg::CLASS_MOVE) && (subclass == cop_isa_pkg::SC_MVGPR);

    // Legal class and subclass pairs
    always_comb begin
        case (iclass)
            cop_isa_pkg::CLASS_MOVE:    legal = is_mvcop || is_mvgpr;
            cop_isa_pkg::CLASS_RANDOM:  legal = (subclass <= cop_isa_pkg::SC_RTEST);
            cop_isa_pkg::CLASS_BITWISE: legal = (subclass <= cop_isa_pkg::SC_ROTL);
            default:                    legal = 1'b0;
        endcase
    end

    // Writeback source select with no write for MVGPR or illegal ops
    always_comb begin
        wr_ben  = 4'b0000;
        wr_data = host_rs1;
        if (rng_sel) wr_data = rng_wdata;
        if (bit_sel) wr_data = bit_wdata;
        if (exec && legal) begin
            if (is_mvcop) wr_ben = 4'b1111;
            if (rng_sel)  wr_ben = rng_ben;  // RSEED gives no enables
            if (bit_sel)  wr_ben = 4'b1111;
        end
    end

    // Handshake FSM
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state     <= ST_IDLE;
            req_q     <= 1'b0;
            cop_ack   <= 1'b0;
            cop_fault <= 1'b0;
        end else begin
            req_q <= cop_req;
            case (state)
                ST_IDLE: if (req_q) state <= ST_EXEC;  // Instruction captured here
                ST_EXEC: begin
                    state     <= ST_ACK;
                    cop_ack   <= 1'b1;
                    cop_fault <= !legal;
                end
                ST_ACK: if (!req_q) begin      // Wait out host back-pressure
                    state   <= ST_IDLE;
                    cop_ack <= 1'b0;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Instruction and result registers
    always_ff @(posedge g_clk) begin
        if (state == ST_IDLE && req_q) instr_q <= cop_instr;
        if (exec) cop_result <= is_mvgpr ? rs1_rdata : '0;
    end

    // Ack only follows a request seen at the IDLE sample edge
    ack_after_req : assert property (@(posedge g_clk) disable iff (!g_resetn)
        $rose(cop_ack) |-> $past(cop_req, 3));

    // Writes land in EXEC for a sampled request and before the ack goes out
    no_write_outside_exec : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (wr_ben != 4'b0000) |-> (state == ST_EXEC) && !cop_ack && $past(cop_req, 2));

endmodule

`default_nettype wire

// File: source/cop_cprs.sv
// Coprocessor register file, two combinational reads and one byte-enabled write
`default_nettype none

`include "cop_macros.svh"

module cop_cprs (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic [`COP_CPR_AW-1:0] rs1_addr,
    input  logic [`COP_CPR_AW-1:0] rs2_addr,
    output logic [31:0]            rs1_rdata,
    output logic [31:0]            rs2_rdata,
    input  logic [`COP_CPR_AW-1:0] wr_addr,
    input  logic [3:0]             wr_ben,     // One enable per byte
    input  logic [31:0]            wr_data
);

    logic [31:0] cprs [`COP_NUM_CPRS];

    // Reads see the state before this edge's write
    assign rs1_rdata = cprs[rs1_addr];
    assign rs2_rdata = cprs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int r = 0; r < `COP_NUM_CPRS; r++) begin
                cprs[r] <= '0;             // All CPRs start at zero
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (wr_ben[b]) cprs[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

    // Write address must be known whenever any byte is written
    wr_addr_known : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (wr_ben != 4'b0000) |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

// File: source/cop_rng.sv
// LFSR random source for the RSEED, RSAMP and RTEST instructions
`default_nettype none

`include "cop_macros.svh"

module cop_rng (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        exec,        // Execute strobe from issue
    input  logic        rng_sel,     // RANDOM class decoded
    input  logic [4:0]  subclass,
    input  logic [31:0] rs1_rdata,   // Seed source
    output logic [31:0] rng_wdata,
    output logic [3:0]  rng_ben
);

    logic [31:0] lfsr;
    logic        n_lsb;
    logic        is_rseed;
    logic        is_rsamp;
    logic        is_rtest;

    assign is_rseed = exec && rng_sel && (subclass == cop_isa_pkg::SC_RSEED);
    assign is_rsamp = exec && rng_sel && (subclass == cop_isa_pkg::SC_RSAMP);
    assign is_rtest = exec && rng_sel && (subclass == cop_isa_pkg::SC_RTEST);

    // XNOR feedback keeps all-zero a legal state
    assign n_lsb = lfsr[cop_rng_pkg::RNG_TAP_A] ~^ lfsr[cop_rng_pkg::RNG_TAP_B] ~^
                   lfsr[cop_rng_pkg::RNG_TAP_C] ~^ lfsr[cop_rng_pkg::RNG_TAP_D];

    // Steps every cycle unless a seed loads
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lfsr <= `COP_RNG_RESET;
        end else if (is_rseed) begin
            lfsr <= rs1_rdata;
        end else begin
            lfsr <= {lfsr[30:0], n_lsb};
        end
    end

    // Sample and test write a full word while seed writes nothing
    assign rng_wdata = is_rtest ? cop_rng_pkg::RTEST_PASS : lfsr;
    assign rng_ben   = (is_rsamp || is_rtest) ? 4'b1111 : 4'b0000;

    // Enables only with the class select and for a single exec cycle
    ben_needs_sel : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (rng_ben != 4'b0000) |-> rng_sel ##1 (rng_ben == 4'b0000));

endmodule

`default_nettype wire

// File: source/cop_bitops.sv
// Bitwise unit computing XOR, AND, OR and rotate-left for the BITWISE class
`default_nettype none

module cop_bitops (
    input  logic        bit_sel,     // BITWISE class decoded
    input  logic [4:0]  subclass,
    input  logic [4:0]  imm,         // Rotate amount
    input  logic [31:0] rs1_rdata,
    input  logic [31:0] rs2_rdata,
    output logic [31:0] bit_wdata
);

    logic [63:0] rot_wide;
    logic [31:0] result;

    // Upper half of the doubled word shifted left is the rotation
    assign rot_wide = {rs1_rdata, rs1_rdata} << imm;

    always_comb begin
        case (subclass)
            cop_isa_pkg::SC_XOR:  result = rs1_rdata ^ rs2_rdata;
            cop_isa_pkg::SC_AND:  result = rs1_rdata & rs2_rdata;
            cop_isa_pkg::SC_OR:   result = rs1_rdata | rs2_rdata;
            cop_isa_pkg::SC_ROTL: result = rot_wide[63:32];
            default:              result = '0;  // Illegal, no write anyway
        endcase
    end

    // Output held at zero unless selected
    assign bit_wdata = bit_sel ? result : '0;

endmodule

`default_nettype wire

// File: source/cop_top.sv
// Coprocessor top level joining issue control, CPR file and execution units
`default_nettype none

`include "cop_macros.svh"

module cop_top (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        cop_req,
    input  logic [31:0] cop_instr,
    input  logic [31:0] host_rs1,
    output logic        cop_ack,
    output logic [31:0] cop_result,
    output logic        cop_fault
);

    logic [`COP_CPR_AW-1:0] rs1_addr;
    logic [`COP_CPR_AW-1:0] rs2_addr;
    logic [`COP_CPR_AW-1:0] wr_addr;
    logic [31:0]            rs1_rdata;
    logic [31:0]            rs2_rdata;
    logic [3:0]             wr_ben;
    logic [31:0]            wr_data;
    logic                   exec;
    logic [4:0]             subclass;
    logic [4:0]             imm;
    logic                   rng_sel;
    logic                   bit_sel;
    logic [31:0]            rng_wdata;
    logic [3:0]             rng_ben;
    logic [31:0]            bit_wdata;

    cop_issue u_issue (
        .g_clk, .g_resetn, .cop_req, .cop_instr, .host_rs1,
        .rs1_rdata, .rng_wdata, .rng_ben, .bit_wdata,
        .cop_ack, .cop_result, .cop_fault,
        .rs1_addr, .rs2_addr, .wr_addr, .wr_ben, .wr_data,
        .exec, .subclass, .imm, .rng_sel, .bit_sel
    );

    cop_cprs u_cprs (
        .g_clk, .g_resetn, .rs1_addr, .rs2_addr, .rs1_rdata, .rs2_rdata,
        .wr_addr, .wr_ben, .wr_data
    );

    cop_rng u_rng (
        .g_clk, .g_resetn, .exec, .rng_sel, .subclass, .rs1_rdata,
        .rng_wdata, .rng_ben
    );

    cop_bitops u_bitops (
        .bit_sel, .subclass, .imm, .rs1_rdata, .rs2_rdata, .bit_wdata
    );

endmodule

`default_nettype wire

// File: verification/tb_cop_top.sv
// Directed testbench for the coprocessor top level against a CPR shadow model
`default_nettype none

`include "cop_macros.svh"

module tb_cop_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_WAIT = 50;           // Cycles allowed per ack edge

    logic        g_clk;
    logic        g_resetn;
    logic        cop_req;
    logic [31:0] cop_instr;
    logic [31:0] host_rs1;
    logic        cop_ack;
    logic [31:0] cop_result;
    logic        cop_fault;

    logic [31:0] shadow [`COP_NUM_CPRS];    // Expected CPR contents
    logic [31:0] stim_lfsr;                 // Stimulus generator state
    int          errors;
    int          timeouts;

    cop_top i_dut (
        .g_clk, .g_resetn, .cop_req, .cop_instr, .host_rs1,
        .cop_ack, .cop_result, .cop_fault
    );

    always #10 g_clk = ~g_clk;              // 20 ns period

    // Galois step giving one output bit per call
    function automatic logic next_bit();
        logic b;
        b = stim_lfsr[0];
        stim_lfsr = (stim_lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], next_bit()};
        end
        return w;
    endfunction

    // Shift left with the XNOR of the taps as new low bit
    function automatic logic [31:0] ref_step(input logic [31:0] x);
        return {x[30:0], ~(x[cop_rng_pkg::RNG_TAP_A] ^ x[cop_rng_pkg::RNG_TAP_B] ^
                           x[cop_rng_pkg::RNG_TAP_C] ^ x[cop_rng_pkg::RNG_TAP_D])};
    endfunction

    // True if to follows from within 1..64 steps
    function automatic logic reachable(input logic [31:0] from, input logic [31:0] to);
        logic [31:0] x;
        x = from;
        for (int k = 1; k <= 64; k++) begin
            x = ref_step(x);
            if (x == to) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] rotl_ref(input logic [31:0] a, input logic [4:0] s);
        return (a << s) | (a >> (32 - s));  // s of zero leaves a
    endfunction

    function automatic cop_isa_pkg::instr_t make_rv(input logic [2:0] cls, input logic [4:0] sc,
                                                    input logic [3:0] rd, input logic [3:0] rs1,
                                                    input logic [3:0] rs2);
        cop_isa_pkg::instr_t i;
        i = '0;
        i.rv.iclass   = cls;
        i.rv.subclass = sc;
        i.rv.rd       = rd;
        i.rv.rs1      = rs1;
        i.rv.rs2      = rs2;
        return i;
    endfunction

    function automatic cop_isa_pkg::instr_t make_iv(input logic [2:0] cls, input logic [4:0] sc,
                                                    input logic [3:0] rd, input logic [3:0] rs1,
                                                    input logic [15:0] imm);
        cop_isa_pkg::instr_t i;
        i = '0;
        i.iv.iclass   = cls;
        i.iv.subclass = sc;
        i.iv.rd       = rd;
        i.iv.rs1      = rs1;
        i.iv.imm      = imm;
        return i;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Full four-phase cycle with req held hold extra cycles after ack
    task automatic issue_instr(input cop_isa_pkg::instr_t instr, input logic [31:0] rs1_val,
                               input int hold, output logic [31:0] result, output logic fault);
        int n;
        @(posedge g_clk);
        cop_req   <= 1'b1;
        cop_instr <= instr;
        host_rs1  <= rs1_val;
        n = 0;
        @(negedge g_clk);
        while (cop_ack !== 1'b1 && n < MAX_WAIT) begin
            @(negedge g_clk);
            n++;
        end
        if (cop_ack !== 1'b1) begin
            timeouts++;
            $display("Timeout: cop_ack never rose after cop_req");
        end
        result = cop_result;                // Valid while ack is high
        fault  = cop_fault;
        for (int c = 0; c < hold; c++) begin
            @(negedge g_clk);
            check_flag("cop_ack", cop_ack, 1'b1);
        end
        @(posedge g_clk);
        cop_req <= 1'b0;
        n = 0;
        @(negedge g_clk);
        while (cop_ack !== 1'b0 && n < MAX_WAIT) begin
            @(negedge g_clk);
            n++;
        end
        if (cop_ack !== 1'b0) begin
            timeouts++;
            $display("Timeout: cop_ack stayed high after cop_req dropped");
        end
    endtask

    // Legal op with no host result
    task automatic exec_op(input cop_isa_pkg::instr_t instr, input logic [31:0] rs1_val);
        logic [31:0] res;
        logic        f;
        issue_instr(instr, rs1_val, 0, res, f);
        check_flag("cop_fault", f, 1'b0);
        check_word("cop_result", res, 32'h0);
    endtask

    task automatic read_cpr(input logic [3:0] idx, output logic [31:0] val);
        logic f;
        issue_instr(make_rv(cop_isa_pkg::CLASS_MOVE, cop_isa_pkg::SC_MVGPR, 4'd0, idx, 4'd0),
                    32'h0, 0, val, f);
        check_flag("cop_fault", f, 1'b0);
    endtask

    task automatic cpr_matches(input logic [3:0] idx);
        logic [31:0] v;
        read_cpr(idx, v);
        check_word($sformatf("cpr[%0d]", idx), v, shadow[idx]);
    endtask

    task automatic moves_roundtrip();
        logic [31:0] w;
        for (int r = 0; r < `COP_NUM_CPRS; r++) begin
            w = rand_bits(32);
            exec_op(make_rv(cop_isa_pkg::CLASS_MOVE, cop_isa_pkg::SC_MVCOP, 4'(r),
                            4'd0, 4'd0), w);
            shadow[r] = w;
        end
        for (int r = 0; r < `COP_NUM_CPRS; r++) begin
            cpr_matches(4'(r));
        end
    endtask

    task automatic bitwise_ops();
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [4:0]  sh;
        logic [31:0] exp;
        cop_isa_pkg::instr_t instr;
        for (int n = 0; n < 12; n++) begin
            rd  = 4'(rand_bits(4));
            rs1 = 4'(rand_bits(4));
            rs2 = 4'(rand_bits(4));
            sh  = 5'(rand_bits(5));
            case (n % 4)
                0: begin
                    exp   = shadow[rs1] ^ shadow[rs2];
                    instr = make_rv(cop_isa_pkg::CLASS_BITWISE, cop_isa_pkg::SC_XOR, rd, rs1, rs2);
                end
                1: begin
                    exp   = shadow[rs1] & shadow[rs2];
                    instr = make_rv(cop_isa_pkg::CLASS_BITWISE, cop_isa_pkg::SC_AND, rd, rs1, rs2);
                end
                2: begin
                    exp   = shadow[rs1] | shadow[rs2];
                    instr = make_rv(cop_isa_pkg::CLASS_BITWISE, cop_isa_pkg::SC_OR, rd, rs1, rs2);
                end
                default: begin
                    exp   = rotl_ref(shadow[rs1], sh);
                    instr = make_iv(cop_isa_pkg::CLASS_BITWISE, cop_isa_pkg::SC_ROTL, rd, rs1,
                                    {11'h0, sh});
                end
            endcase
            exec_op(instr, rand_bits(32));  // Host value must be ignored
            shadow[rd] = exp;
            cpr_matches(rd);
        end
    endtask

    task automatic seed_and_sample();
        logic [31:0] seed;
        logic [31:0] s1;
        logic [31:0] s2;
        seed = rand_bits(32);
        exec_op(make_rv(cop_isa_pkg::CLASS_MOVE, cop_isa_pkg::SC_MVCOP, 4'd1, 4'd0, 4'd0), seed);
        shadow[1] = seed;
        exec_op(make_rv(cop_isa_pkg::CLASS_RANDOM, cop_isa_pkg::SC_RSEED, 4'd2, 4'd1, 4'd0), 0);
        exec_op(make_rv(cop_isa_pkg::CLASS_RANDOM, cop_isa_pkg::SC_RSAMP, 4'd3, 4'd0, 4'd0), 0);
        read_cpr(4'd3, s1);
        shadow[3] = s1;
        check_flag("rsamp reachable from seed", reachable(seed, s1), 1'b1);
        exec_op(make_rv(cop_isa_pkg::CLASS_RANDOM, cop_isa_pkg::SC_RSAMP, 4'd4, 4'd0, 4'd0), 0);
        read_cpr(4'd4, s2);
        shadow[4] = s2;
        check_flag("second rsamp later state", reachable(s1, s2), 1'b1);
    endtask

    task automatic rtest_and_rseed();
        exec_op(make_rv(cop_isa_pkg::CLASS_RANDOM, cop_isa_pkg::SC_RTEST, 4'd5, 4'd0, 4'd0), 0);
        shadow[5] = cop_rng_pkg::RTEST_PASS;
        cpr_matches(4'd5);
        exec_op(make_rv(cop_isa_pkg::CLASS_RANDOM, cop_isa_pkg::SC_RSEED, 4'd6, 4'd7, 4'd0), 0);
        cpr_matches(4'd6);                  // Seed has no writeback
    endtask

    task automatic illegal_instrs();
        cop_isa_pkg::instr_t bad [5];
        logic [31:0] res;
        logic        f;
        bad[0] = make_rv(3'd0, 5'd0, 4'(rand_bits(4)), 4'(rand_bits(4)), 4'(rand_bits(4)));
        bad[1] = make_rv(3'd6, 5'd1, 4'(rand_bits(4)), 4'(rand_bits(4)), 4'(rand_bits(4)));
        bad[2] = make_rv(cop_isa_pkg::CLASS_MOVE, 5'd2, 4'(rand_bits(4)), 4'(rand_bits(4)),
                         4'd0);
        bad[3] = make_rv(cop_isa_pkg::CLASS_RANDOM, 5'd3, 4'(rand_bits(4)), 4'(rand_bits(4)),
                         4'd0);
        bad[4] = make_rv(cop_isa_pkg::CLASS_BITWISE, 5'd4, 4'(rand_bits(4)), 4'(rand_bits(4)),
                         4'd0);
        for (int i = 0; i < 5; i++) begin
            issue_instr(bad[i], rand_bits(32), 0, res, f);
            check_flag("cop_fault", f, 1'b1);
            check_word("cop_result", res, 32'h0);
        end
        for (int r = 0; r < `COP_NUM_CPRS; r++) begin
            cpr_matches(4'(r));             // Nothing written
        end
    endtask

    // Host keeps req up five extra cycles
    task automatic handshake_hold();
        logic [31:0] w;
        logic [31:0] res;
        logic        f;
        w = rand_bits(32);
        issue_instr(make_rv(cop_isa_pkg::CLASS_MOVE, cop_isa_pkg::SC_MVCOP, 4'd8, 4'd0, 4'd0),
                    w, 5, res, f);
        check_flag("cop_fault", f, 1'b0);
        shadow[8] = w;
        cpr_matches(4'd8);
    endtask

    initial begin
        g_clk     = 1'b0;
        g_resetn  = 1'b0;
        cop_req   = 1'b0;
        cop_instr = '0;
        host_rs1  = '0;
        stim_lfsr = 32'd79;
        errors    = 0;
        timeouts  = 0;
        for (int r = 0; r < `COP_NUM_CPRS; r++) begin
            shadow[r] = '0;                 // CPRs clear at reset
        end
        repeat (2) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        check_flag("cop_ack", cop_ack, 1'b0);
        moves_roundtrip();
        bitwise_ops();
        seed_and_sample();
        rtest_and_rseed();
        illegal_instrs();
        handshake_hold();
        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cop_top.f
+incdir+source
source/cop_isa_pkg.sv
source/cop_rng_pkg.sv
source/cop_issue.sv
source/cop_cprs.sv
source/cop_rng.sv
source/cop_bitops.sv
source/cop_top.sv
verification/tb_cop_top.sv

// File: Bender.yml
package:
  name: cop_top

sources:
  - include_dirs:
      - source
    files:
      - source/cop_isa_pkg.sv
      - source/cop_rng_pkg.sv
      - source/cop_issue.sv
      - source/cop_cprs.sv
      - source/cop_rng.sv
      - source/cop_bitops.sv
      - source/cop_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_cop_top.sv
